//--- Makefile
# Verilator build and run of the frame store testbench

VERILATOR       ?= verilator
TOP             ?= display_frame_tb
FLIST           ?= flist.f
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert
LINT_FLAGS      ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) -Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

//--- flist.f
verilog/display_pkg.sv
verilog/pixel_buffer.sv
verilog/buffer_router.sv
verilog/buffer_control.sv
verilog/raster_scan.sv
verilog/display_frame_top.sv
verification/display_frame_tb.sv

//--- verification/display_frame_tb.sv
// directed testbench for the double-buffered frame store, 16 x 8 frame
// scanning stays on from the first test, so every frame runs back to back
// a model of both buffers and the front flag predicts each scanned frame
// tests run in order and rely on the buffer contents left by earlier ones

`timescale 1ns/1ps

module display_frame_tb;
  import display_pkg::*;

  localparam int frame_width  = 16;
  localparam int frame_height = 8;
  localparam int frame_pixels = frame_width * frame_height;
  // a full frame to reach the boundary, with slack
  localparam int wait_limit = 3 * frame_pixels;

  logic         clock_in;
  logic         reset_n_in;
  logic         write_valid;
  pixel_write_t write_request;
  logic         write_ready;
  logic         swap_request;
  logic         swap_done;
  logic         scan_enable;
  logic         scan_valid;
  scan_pixel_t  scan_pixel;

  // reference model of both rams
  pixel_t     model_a [frame_pixels];
  pixel_t     model_b [frame_pixels];
  buffer_id_t model_front;

  integer seed;
  int     error_count;
  int     check_count;
  int     test_count;
  // error count when the current test started
  int     test_start_errors;
  // cycles the last compare_frame spent waiting for a frame start
  int     start_wait;

  display_frame_top #(
    .frame_width  (frame_width),
    .frame_height (frame_height)
  ) display_frame_top_i (
    .clock_in      (clock_in),
    .reset_n_in    (reset_n_in),
    .write_valid   (write_valid),
    .write_request (write_request),
    .write_ready   (write_ready),
    .swap_request  (swap_request),
    .swap_done     (swap_done),
    .scan_enable   (scan_enable),
    .scan_valid    (scan_valid),
    .scan_pixel    (scan_pixel)
  );

  // 10 ns clock, low for the first half period
  always begin
    clock_in = 1'b0;
    #5;
    clock_in = 1'b1;
    #5;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_problem(input string what);
    error_count++;
    $display("%s", what);
  endtask

  task automatic close_test(input string name);
    test_count++;
    $display("test %s finished, %0d errors", name, error_count - test_start_errors);
    test_start_errors = error_count;
  endtask

  // an accepted write lands in whichever buffer is the back one
  function automatic void store_model(input int index, input pixel_t data);
    if (model_front == buffer_a) begin
      model_b[index] = data;
    end else begin
      model_a[index] = data;
    end
  endfunction

  function automatic pixel_t expected_pixel(input int index);
    if (model_front == buffer_a) begin
      return model_a[index];
    end
    return model_b[index];
  endfunction

  // one write, held until ready is seen, then dropped after the accept edge
  task automatic write_pixel(input pixel_address_t pixel_address, input pixel_t pixel_data);
    int waited;
    waited = 0;
    @(posedge clock_in);
    write_valid   <= 1'b1;
    write_request <= '{address: pixel_address, data: pixel_data};
    @(negedge clock_in);
    while (!write_ready && waited < wait_limit) begin
      waited++;
      @(negedge clock_in);
    end
    if (write_ready) begin
      store_model(int'(pixel_address), pixel_data);
    end else begin
      report_problem("write port never became ready");
    end
    @(posedge clock_in);
    write_valid <= 1'b0;
  endtask

  // optionally checks that writes stay stalled while the swap is pending
  task automatic wait_swap_done(input bit check_stall);
    int waited;
    waited = 0;
    @(negedge clock_in);
    while (!swap_done && waited < wait_limit) begin
      if (check_stall) begin
        check_value("pending write_ready", 32'(1'b0), 32'(write_ready));
      end
      waited++;
      @(negedge clock_in);
    end
    if (swap_done) begin
      model_front = (model_front == buffer_a) ? buffer_b : buffer_a;
    end else begin
      report_problem("swap_done never pulsed after a swap request");
    end
  endtask

  task automatic request_swap();
    @(posedge clock_in);
    swap_request <= 1'b1;
    wait_swap_done(1'b0);
    // level back low so the next request is a fresh edge
    @(posedge clock_in);
    swap_request <= 1'b0;
  endtask

  // waits for the next frame start, then checks every pixel against the model
  task automatic compare_frame(input string name);
    int waited;
    bit stream_ok;
    waited    = 0;
    stream_ok = 1'b1;
    @(negedge clock_in);
    while (!(scan_valid && scan_pixel.frame_first) && waited < wait_limit) begin
      waited++;
      @(negedge clock_in);
    end
    start_wait = waited;
    if (!(scan_valid && scan_pixel.frame_first)) begin
      report_problem({name, ": no frame start seen on the pixel stream"});
      stream_ok = 1'b0;
    end
    for (int i = 0; i < frame_pixels && stream_ok; i++) begin
      if (i > 0) begin
        @(negedge clock_in);
      end
      waited = 0;
      while (!scan_valid && waited < wait_limit) begin
        waited++;
        @(negedge clock_in);
      end
      if (!scan_valid) begin
        report_problem({name, ": pixel stream stopped inside a frame"});
        stream_ok = 1'b0;
      end else begin
        check_value({name, " data"}, 32'(expected_pixel(i)), 32'(scan_pixel.data));
        check_value({name, " frame_first"}, 32'(i == 0), 32'(scan_pixel.frame_first));
      end
    end
  endtask

  task automatic reset_state_test();
    @(negedge clock_in);
    check_value("reset write_ready", 32'(1'b1), 32'(write_ready));
    check_value("reset swap_done", 32'(1'b0), 32'(swap_done));
    check_value("reset scan_valid", 32'(1'b0), 32'(scan_valid));
    @(posedge clock_in);
    scan_enable <= 1'b1;
    compare_frame("reset frame");
    close_test("after reset");
  endtask

  // pattern goes to the back buffer, front stays blank
  task automatic back_buffer_isolation_test();
    for (int i = 0; i < frame_pixels; i++) begin
      write_pixel(pixel_address_t'(i), pixel_t'($random(seed)));
    end
    compare_frame("isolation frame");
    close_test("back buffer isolation");
  endtask

  // address 0 is issued in the swap_done cycle and its pixel shows 2 cycles on
  // request_swap uses up one of those cycles, so one more is left to wait
  task automatic frame_boundary_swap_test();
    request_swap();
    compare_frame("swapped frame");
    check_value("swapped frame start delay", 32'd1, 32'(start_wait));
    close_test("frame boundary swap");
  endtask

  // scrambled order, so each write must keep the nibbles written before it
  task automatic nibble_packing_test();
    int word_base;
    int position;
    word_base = 5 * pixels_per_word;
    for (int i = 0; i < pixels_per_word; i++) begin
      position = (i * 3) % pixels_per_word;
      write_pixel(pixel_address_t'(word_base + position), pixel_t'(15 - position));
    end
    request_swap();
    compare_frame("packed word frame");
    request_swap();
    compare_frame("second swap frame");
    close_test("nibble packing");
  endtask

  task automatic pending_swap_stall_test();
    pixel_address_t stall_address;
    pixel_t         stall_data;
    stall_address = pixel_address_t'(77);
    // new back buffer after this swap is b
    stall_data = ~model_b[77];
    @(posedge clock_in);
    swap_request <= 1'b1;
    // swap is pending from the next edge on
    @(posedge clock_in);
    write_valid   <= 1'b1;
    write_request <= '{address: stall_address, data: stall_data};
    @(negedge clock_in);
    check_value("stalled write_ready", 32'(1'b0), 32'(write_ready));
    wait_swap_done(1'b1);
    check_value("released write_ready", 32'(1'b1), 32'(write_ready));
    // held write goes through at this edge
    @(posedge clock_in);
    write_valid  <= 1'b0;
    swap_request <= 1'b0;
    store_model(int'(stall_address), stall_data);
    compare_frame("stalled write hidden");
    request_swap();
    compare_frame("stalled write shown");
    close_test("pending swap stall");
  endtask

  initial begin
    seed              = 32'h4142aeff;
    error_count       = 0;
    check_count       = 0;
    test_count        = 0;
    test_start_errors = 0;
    start_wait        = 0;
    reset_n_in        = 1'b0;
    write_valid       = 1'b0;
    write_request     = '0;
    swap_request      = 1'b0;
    scan_enable       = 1'b0;
    model_front       = buffer_a;
    for (int i = 0; i < frame_pixels; i++) begin
      model_a[i] = '0;
      model_b[i] = '0;
    end
    repeat (10) @(posedge clock_in);
    reset_n_in <= 1'b1;

    reset_state_test();
    back_buffer_isolation_test();
    frame_boundary_swap_test();
    nibble_packing_test();
    pending_swap_stall_test();

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/buffer_control.sv
// front buffer tracking and swap handshake
// a rising edge on swap_request arms a swap, taken at the next frame_last
// write_ready is low while a swap is pending, so no write straddles the swap
// edges seen while a swap is already pending are dropped

`timescale 1ns/1ps

module buffer_control
  import display_pkg::*;
(
  input  logic       clock_in,
  input  logic       reset_n_in,
  input  logic       swap_request,
  input  logic       frame_last,
  input  logic       write_valid,
  output logic       write_ready,
  output logic       write_accept,
  output buffer_id_t front_buffer,
  output logic       swap_done
);

  typedef enum logic {
    swap_idle,
    swap_pending
  } swap_state_t;

  swap_state_t swap_state;

  // last sample of the swap level, for edge detect
  logic swap_request_q;
  logic swap_rise;

  assign swap_rise = swap_request && !swap_request_q;

  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      swap_state     <= swap_idle;
      front_buffer   <= buffer_a;
      swap_done      <= 1'b0;
      swap_request_q <= 1'b0;
    end else begin
      swap_request_q <= swap_request;
      // pulse by default low
      swap_done      <= 1'b0;
      case (swap_state)
        swap_idle: begin
          if (swap_rise) begin
            swap_state <= swap_pending;
          end
        end
        swap_pending: begin
          // last address of the frame is out, flip for address 0
          if (frame_last) begin
            front_buffer <= (front_buffer == buffer_a) ? buffer_b : buffer_a;
            swap_state   <= swap_idle;
            swap_done    <= 1'b1;
          end
        end
        default: swap_state <= swap_idle;
      endcase
    end
  end

  // stall writes until the new back buffer is settled
  assign write_ready  = (swap_state == swap_idle);
  assign write_accept = write_valid && write_ready;

  // at most one swap per frame boundary
  assert property (@(posedge clock_in) disable iff (!reset_n_in)
    swap_done |=> !swap_done);

endmodule

//--- verilog/buffer_router.sv
// routes the raster read to the front ram and pixel writes to the back ram
// every ram-side signal is registered, so accepted writes land one cycle late
// front_data is combinational from the ram outputs, 2 cycles after read_address

`timescale 1ns/1ps

module buffer_router
  import display_pkg::*;
(
  input  logic           clock_in,
  input  logic           reset_n_in,
  input  buffer_id_t     front_buffer,
  input  pixel_address_t read_address,
  input  logic           write_accept,
  input  pixel_write_t   write_request,
  input  pixel_t         read_data_a,
  input  pixel_t         read_data_b,
  output pixel_address_t address_a,
  output pixel_address_t address_b,
  output pixel_t         write_data,
  output logic           write_enable_a,
  output logic           write_enable_b,
  output pixel_t         front_data
);

  // select that went out with the addresses
  buffer_id_t select_address;
  // same select one cycle on, lined up with ram read data
  buffer_id_t select_data;

  // addresses and write data, front ram reads and back ram writes
  always_ff @(posedge clock_in) begin
    write_data <= write_request.data;
    if (front_buffer == buffer_a) begin
      address_a <= read_address;
      address_b <= write_request.address;
    end else begin
      address_a <= write_request.address;
      address_b <= read_address;
    end
  end

  // enables and select pipeline
  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      write_enable_a <= 1'b0;
      write_enable_b <= 1'b0;
      select_address <= buffer_a;
      select_data    <= buffer_a;
    end else begin
      // only the back ram is ever written
      write_enable_a <= write_accept && (front_buffer == buffer_b);
      write_enable_b <= write_accept && (front_buffer == buffer_a);
      select_address <= front_buffer;
      select_data    <= select_address;
    end
  end

  // pick the nibble from whichever ram served the read
  assign front_data = (select_data == buffer_a) ? read_data_a : read_data_b;

  // a registered write still targets the back ram when it lands
  assert property (@(posedge clock_in) disable iff (!reset_n_in)
    write_accept |=> $stable(front_buffer));

endmodule

//--- verilog/display_frame_top.sv
// double-buffered 4-bit frame store, default 16 x 8 pixels
// writes go to the back buffer over valid/ready; the scan reads the front
// scan_pixel follows each issued address by 2 cycles, no back-pressure
// the sink must take one pixel per cycle while scan_valid is high

`timescale 1ns/1ps

module display_frame_top
  import display_pkg::*;
#(
  parameter int frame_width  = 16,
  parameter int frame_height = 8
) (
  input  logic         clock_in,
  input  logic         reset_n_in,
  input  logic         write_valid,
  input  pixel_write_t write_request,
  output logic         write_ready,
  input  logic         swap_request,
  output logic         swap_done,
  input  logic         scan_enable,
  output logic         scan_valid,
  output scan_pixel_t  scan_pixel
);

  localparam int frame_pixels = frame_width * frame_height;

  // control and scan
  buffer_id_t     front_buffer;
  logic           write_accept;
  logic           frame_last;
  pixel_address_t read_address;
  logic           first_delayed;
  logic           valid_delayed;

  // ram side
  pixel_address_t address_a;
  pixel_address_t address_b;
  pixel_t         write_data;
  logic           write_enable_a;
  logic           write_enable_b;
  pixel_t         read_data_a;
  pixel_t         read_data_b;
  pixel_t         front_data;

  buffer_control buffer_control_i (
    .clock_in     (clock_in),
    .reset_n_in   (reset_n_in),
    .swap_request (swap_request),
    .frame_last   (frame_last),
    .write_valid  (write_valid),
    .write_ready  (write_ready),
    .write_accept (write_accept),
    .front_buffer (front_buffer),
    .swap_done    (swap_done)
  );

  raster_scan #(
    .frame_width  (frame_width),
    .frame_height (frame_height),
    .frame_pixels (frame_pixels)
  ) raster_scan_i (
    .clock_in      (clock_in),
    .reset_n_in    (reset_n_in),
    .scan_enable   (scan_enable),
    .read_address  (read_address),
    .frame_last    (frame_last),
    .first_delayed (first_delayed),
    .valid_delayed (valid_delayed)
  );

  buffer_router buffer_router_i (
    .clock_in       (clock_in),
    .reset_n_in     (reset_n_in),
    .front_buffer   (front_buffer),
    .read_address   (read_address),
    .write_accept   (write_accept),
    .write_request  (write_request),
    .read_data_a    (read_data_a),
    .read_data_b    (read_data_b),
    .address_a      (address_a),
    .address_b      (address_b),
    .write_data     (write_data),
    .write_enable_a (write_enable_a),
    .write_enable_b (write_enable_b),
    .front_data     (front_data)
  );

  pixel_buffer #(
    .frame_pixels (frame_pixels)
  ) buffer_a_i (
    .clock_in     (clock_in),
    .reset_n_in   (reset_n_in),
    .address      (address_a),
    .write_data   (write_data),
    .write_enable (write_enable_a),
    .read_data    (read_data_a)
  );

  pixel_buffer #(
    .frame_pixels (frame_pixels)
  ) buffer_b_i (
    .clock_in     (clock_in),
    .reset_n_in   (reset_n_in),
    .address      (address_b),
    .write_data   (write_data),
    .write_enable (write_enable_b),
    .read_data    (read_data_b)
  );

  // ram nibble joined with the delayed scan flags
  assign scan_pixel = '{data: front_data, frame_first: first_delayed};
  assign scan_valid = valid_delayed;

endmodule

//--- verilog/display_pkg.sv
// shared types for the double-buffered 4-bit grey-scale frame store
// pixel addresses are linear, row-major, 18 bits wide (up to 640 x 400)
// the low 3 address bits pick a nibble, the rest pick a 32-bit word

package display_pkg;

  // one grey-scale pixel
  typedef logic [3:0] pixel_t;

  // linear pixel index, row-major
  typedef logic [17:0] pixel_address_t;

  // eight nibbles per 32-bit ram word
  localparam int pixels_per_word = 8;

  // which ram currently feeds the display
  typedef enum logic {
    buffer_a = 1'b0,
    buffer_b = 1'b1
  } buffer_id_t;

  // payload of the pixel write port
  typedef struct packed {
    pixel_address_t address;
    pixel_t         data;
  } pixel_write_t;

  // payload of the outgoing pixel stream
  typedef struct packed {
    pixel_t data;
    // high on pixel 0 of a frame only
    logic   frame_first;
  } scan_pixel_t;

endpackage

//--- verilog/pixel_buffer.sv
// one frame buffer, 32-bit words holding eight 4-bit pixels each
// single address port shared by the read and the nibble write
// read data is registered, 1-cycle latency; read-during-write gives old data
// contents start zeroed in simulation and have no reset

`timescale 1ns/1ps

module pixel_buffer
  import display_pkg::*;
#(
  parameter int frame_pixels = 128
) (
  input  logic           clock_in,
  input  logic           reset_n_in,
  input  pixel_address_t address,
  input  pixel_t         write_data,
  input  logic           write_enable,
  output pixel_t         read_data
);

  // round up so a partial last word still has storage
  localparam int buffer_words = (frame_pixels + pixels_per_word - 1) / pixels_per_word;
  localparam int word_bits = (buffer_words > 1) ? $clog2(buffer_words) : 1;

  logic [31:0] memory [buffer_words];

  logic [word_bits-1:0] word_index;
  logic [2:0]           nibble_index;

  // upper bits select the word, low 3 bits the nibble
  assign word_index   = address[word_bits+2:3];
  assign nibble_index = address[2:0];

  // simulation model starts with a blank frame
  initial begin
    for (int i = 0; i < buffer_words; i++) begin
      memory[i] = '0;
    end
  end

  // nibble write, the other seven pixels of the word stay untouched
  always_ff @(posedge clock_in) begin
    if (write_enable) begin
      memory[word_index][nibble_index*4 +: 4] <= write_data;
    end
  end

  // registered nibble read
  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      read_data <= '0;
    end else begin
      read_data <= memory[word_index][nibble_index*4 +: 4];
    end
  end

endmodule

//--- verilog/raster_scan.sv
// raster address generator, one pixel address per enabled cycle
// frame_last is high while address frame_pixels-1 is issued
// valid and frame-first come out 2 cycles late, matching router plus ram
// dropping scan_enable pauses the scan at the next unissued address

`timescale 1ns/1ps

module raster_scan
  import display_pkg::*;
#(
  parameter int frame_width  = 16,
  parameter int frame_height = 8,
  parameter int frame_pixels = 128
) (
  input  logic           clock_in,
  input  logic           reset_n_in,
  input  logic           scan_enable,
  output pixel_address_t read_address,
  output logic           frame_last,
  output logic           first_delayed,
  output logic           valid_delayed
);

  localparam pixel_address_t last_address = pixel_address_t'(frame_pixels - 1);

  // raster position of the issued address
  logic [$clog2(frame_width+1)-1:0]  column_count;
  logic [$clog2(frame_height+1)-1:0] row_count;

  logic       frame_first;
  logic [1:0] valid_stage;
  logic [1:0] first_stage;

  assign frame_first = (row_count == '0) && (column_count == '0);
  // only counts as last while the address is really issued
  assign frame_last  = scan_enable && (read_address == last_address);

  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      read_address <= '0;
      column_count <= '0;
      row_count    <= '0;
      valid_stage  <= '0;
      first_stage  <= '0;
    end else begin
      valid_stage <= {valid_stage[0], scan_enable};
      first_stage <= {first_stage[0], scan_enable && frame_first};
      if (scan_enable) begin
        read_address <= frame_last ? '0 : read_address + pixel_address_t'(1);
        // column and row step in step with the linear counter
        if (column_count == ($bits(column_count))'(frame_width - 1)) begin
          column_count <= '0;
          if (row_count == ($bits(row_count))'(frame_height - 1)) begin
            row_count <= '0;
          end else begin
            row_count <= row_count + 1'b1;
          end
        end else begin
          column_count <= column_count + 1'b1;
        end
      end
    end
  end

  assign valid_delayed = valid_stage[1];
  assign first_delayed = first_stage[1];

  // column stays inside a line, and row and column agree with the linear address
  assert property (@(posedge clock_in) disable iff (!reset_n_in)
    (column_count < ($bits(column_count))'(frame_width)) &&
    (read_address == pixel_address_t'(int'(row_count) * frame_width + int'(column_count))));

endmodule
